// File: cnn_pool_patterns.txt
// Per test: opcode word (0 max, 1 avg), 64 input pixels as 8 rows of 8, 16 expected outputs
// Each word is ch2 ch1 ch0, 16 bits per channel, outputs in raster order
// Test 1: max pooling, all values positive
0
700701770000 710701760001 720701750002 730701740003 740701730004 750701720005 760701710006 770701700007
700601670010 710601660011 720601650012 730601640013 740601630014 750601620015 760601610016 770601600017
700501570020 710501560021 720501550022 730501540023 740501530024 750501520025 760501510026 770501500027
700401470030 710401460031 720401450032 730401440033 740401430034 750401420035 760401410036 770401400037
700301370040 710301360041 720301350042 730301340043 740301330044 750301320045 760301310046 770301300047
700201270050 710201260051 720201250052 730201240053 740201230054 750201220055 760201210056 770201200057
700101170060 710101160061 720101150062 730101140063 740101130064 750101120065 760101110066 770101100067
700001070070 710001060071 720001050072 730001040073 740001030074 750001020075 760001010076 770001000077
710701770011 730701750013 750701730015 770701710017 710501570031 730501550033 750501530035 770501510037
710301370051 730301350053 750301330055 770301310057 710101170071 730101150073 750101130075 770101110077
// Test 2: average pooling, ch1 negative on even columns, odd window sums
1
7FFC80000000 7FFE00010001 7FFC80020002 7FFE00030003 7FFC80040004 7FFE00050005 7FFC80060006 7FFE00070007
7FFD80100008 7FFF00110009 7FFD8012000A 7FFF0013000B 7FFD8014000C 7FFF0015000D 7FFD8016000E 7FFF0017000F
7FFC80200010 7FFE00210011 7FFC80220012 7FFE00230013 7FFC80240014 7FFE00250015 7FFC80260016 7FFE00270017
7FFD80300018 7FFF00310019 7FFD8032001A 7FFF0033001B 7FFD8034001C 7FFF0035001D 7FFD8036001E 7FFF0037001F
7FFC80400020 7FFE00410021 7FFC80420022 7FFE00430023 7FFC80440024 7FFE00450025 7FFC80460026 7FFE00470027
7FFD80500028 7FFF00510029 7FFD8052002A 7FFF0053002B 7FFD8054002C 7FFF0055002D 7FFD8056002E 7FFF0057002F
7FFC80600030 7FFE00610031 7FFC80620032 7FFE00630033 7FFC80640034 7FFE00650035 7FFC80660036 7FFE00670037
7FFD80700038 7FFF00710039 7FFD8072003A 7FFF0073003B 7FFD8074003C 7FFF0075003D 7FFD8076003E 7FFF0077003F
7FFD00040004 7FFD00050006 7FFD00060008 7FFD0007000A 7FFD00140014 7FFD00150016 7FFD00160018 7FFD0017001A
7FFD00240024 7FFD00250026 7FFD00260028 7FFD0027002A 7FFD00340034 7FFD00350036 7FFD00360038 7FFD0037003A
// Test 3: max pooling, ch0 all negative, ch1 mostly negative
0
20708000F000 21708001F001 22708002F002 23708003F003 24708004F004 25708005F005 26708006F006 27708007F007
20600010F010 21608011F011 22600012F012 23608013F013 24600014F014 25608015F015 26600016F016 27608017F017
20508020F020 21508021F021 22508022F022 23508023F023 24508024F024 25508025F025 26508026F026 27508027F027
20400030F030 21408031F031 22400032F032 23408033F033 24400034F034 25408035F035 26400036F036 27408037F037
20308040F040 21308041F041 22308042F042 23308043F043 24308044F044 25308045F045 26308046F046 27308047F047
20200050F050 21208051F051 22200052F052 23208053F053 24200054F054 25208055F055 26200056F056 27208057F057
20108060F060 21108061F061 22108062F062 23108063F063 24108064F064 25108065F065 26108066F066 27108067F067
20000070F070 21008071F071 22000072F072 23008073F073 24000074F074 25008075F075 26000076F076 27008077F077
217000100000 237000120000 257000140000 277000160000 215000300000 235000320000 255000340000 275000360000
213000500000 233000520000 253000540000 273000560000 211000700000 231000720000 251000740000 271000760000

// File: cnn_pool_top.f
cnn_geom_pkg.sv
cnn_ctrl_pkg.sv
relu_stage.sv
line_buffer.sv
pool_unit.sv
pool_ctrl.sv
cnn_pool_top.sv
tb_cnn_pool_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pooling testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cnn_pool_top -f cnn_pool_top.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_cnn_pool_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
exit 1

// File: tb_cnn_pool_top.sv
module tb_cnn_pool_top
    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS      = 3;
    localparam int NUM_PIX        = IMG_W * IMG_H;
    localparam int NUM_OUT        = POOL_W * (IMG_H / 2);
    // Opcode word, input pixels, expected outputs
    localparam int WORDS_PER_TEST = 1 + NUM_PIX + NUM_OUT;
    localparam int TIMEOUT_CYC    = 1000;

    logic                 clk;
    logic                 reset_n;
    logic                 i_valid;
    logic                 o_ready;
    logic [CI*PIX_BW-1:0] i_pixel;
    pool_op_e             i_pool_op;
    logic                 o_valid;
    logic [CI*PIX_BW-1:0] o_pool;
    logic                 o_last;
    logic                 i_ready;

    logic [CI*PIX_BW-1:0] pat_mem [NUM_TESTS*WORDS_PER_TEST];
    integer               seed = 32'h6ae3_d6bd;
    logic [31:0]          rnd;
    logic                 drop_valid;
    logic                 timeout_hit;
    int                   err_count;
    int                   pass_count;
    int                   fail_count;
    // Output seen stalled on the previous edge
    logic                 held;
    logic [CI*PIX_BW-1:0] held_pool;
    logic                 held_last;

    cnn_pool_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_valid   (i_valid),
        .o_ready   (o_ready),
        .i_pixel   (i_pixel),
        .i_pool_op (i_pool_op),
        .o_valid   (o_valid),
        .o_pool    (o_pool),
        .o_last    (o_last),
        .i_ready   (i_ready)
    );

    always #2 clk = ~clk;

    // Random sink stalls and source gaps
    always @(posedge clk) begin
        rnd = $random(seed);
        i_ready    <= (rnd[1:0] != 2'b00);
        drop_valid <= (rnd[3:2] == 2'b00);
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    //////////////////////////////
    // Pixel source
    //////////////////////////////

    task automatic send_pixel(input logic [CI*PIX_BW-1:0] pix, input pool_op_e op);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        if (drop_valid) begin
            i_valid <= 1'b0;
            @(posedge clk);
        end
        i_valid   <= 1'b1;
        i_pixel   <= pix;
        i_pool_op <= op;
        while (!accepted && !timeout_hit && waited < TIMEOUT_CYC) begin
            @(posedge clk);
            waited++;
            accepted = o_ready;
        end
        if (!accepted && !timeout_hit) begin
            $display("Timed out: o_ready stayed low, the pixel was never accepted");
            timeout_hit = 1'b1;
        end
    endtask

    task automatic drive_frames();
        pool_op_e op;
        int       base;
        // Frames go back to back with no idle gap
        for (int t = 0; t < NUM_TESTS; t++) begin
            base = t * WORDS_PER_TEST;
            op   = pool_op_e'(pat_mem[base][0]);
            for (int p = 0; p < NUM_PIX; p++) begin
                if (!timeout_hit) send_pixel(pat_mem[base+1+p], op);
            end
        end
        i_valid <= 1'b0;
    endtask

    //////////////////////////////
    // Output sink and checks
    //////////////////////////////

    task automatic wait_output(output logic got);
        int waited;
        waited = 0;
        got    = 1'b0;
        while (!got && !timeout_hit && waited < TIMEOUT_CYC) begin
            @(posedge clk);
            waited++;
            if (held) begin
                check_value("o_valid while held", o_valid, 1'b1);
                check_value("o_pool while held", o_pool, held_pool);
                check_value("o_last while held", o_last, held_last);
            end
            held = o_valid && !i_ready;
            if (held) begin
                check_value("o_ready while output held", o_ready, 1'b0);
                held_pool = o_pool;
                held_last = o_last;
            end
            got = o_valid && i_ready;
        end
        if (!got && !timeout_hit) begin
            $display("Timed out: no output handshake within %0d cycles", TIMEOUT_CYC);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic check_frames();
        pool_op_e op;
        int       base;
        int       errs_before;
        logic     got;
        for (int t = 0; t < NUM_TESTS && !timeout_hit; t++) begin
            base        = t * WORDS_PER_TEST;
            op          = pool_op_e'(pat_mem[base][0]);
            errs_before = err_count;
            for (int k = 0; k < NUM_OUT && !timeout_hit; k++) begin
                wait_output(got);
                if (got) begin
                    check_value($sformatf("test %0d output %0d o_pool", t + 1, k),
                                o_pool, pat_mem[base+1+NUM_PIX+k]);
                    // Only the final window of the frame carries o_last
                    check_value($sformatf("test %0d output %0d o_last", t + 1, k),
                                o_last, (k == NUM_OUT - 1));
                end
            end
            if (timeout_hit || err_count != errs_before) begin
                fail_count++;
                $display("Test %0d (%s): mismatches or timeout", t + 1, op.name());
            end else begin
                pass_count++;
                $display("Test %0d (%s): %0d outputs match", t + 1, op.name(), NUM_OUT);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        i_valid     = 1'b0;
        i_pixel     = '0;
        i_pool_op   = POOL_MAX;
        i_ready     = 1'b0;
        drop_valid  = 1'b0;
        timeout_hit = 1'b0;
        held        = 1'b0;
        held_pool   = '0;
        held_last   = 1'b0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        $readmemh("cnn_pool_patterns.txt", pat_mem);
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        fork
            drive_frames();
            check_frames();
        join
        $display("Tests passed: %0d, tests failed: %0d, value errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && pass_count == NUM_TESTS && !timeout_hit) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: cnn_pool_top.sv
module cnn_pool_top
    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 i_valid,
    output logic                 o_ready,
    input  logic [CI*PIX_BW-1:0] i_pixel,
    input  pool_op_e             i_pool_op,

    output logic                 o_valid,
    output logic [CI*PIX_BW-1:0] o_pool,
    output logic                 o_last,
    input  logic                 i_ready
);

    logic [CI*PIX_BW-1:0] relu_pix;
    logic [CI*PIX_BW-1:0] pool_res;
    logic                 shift;
    logic [COL_BW-1:0]    col;
    pool_op_e             op;

    relu_stage u_relu (
        .i_pixel (i_pixel),
        .o_pixel (relu_pix)
    );

    //////////////////////////////
    // Per-channel datapath
    //////////////////////////////

    for (genvar c = 0; c < CI; c++) begin : g_ch
        logic [PIX_BW-1:0] win00;
        logic [PIX_BW-1:0] win01;
        logic [PIX_BW-1:0] win10;
        logic [PIX_BW-1:0] win11;

        line_buffer u_line_buffer (
            .clk     (clk),
            .reset_n (reset_n),
            .i_shift (shift),
            .i_pixel (relu_pix[c*PIX_BW +: PIX_BW]),
            .i_col   (col),
            .o_win00 (win00),
            .o_win01 (win01),
            .o_win10 (win10),
            .o_win11 (win11)
        );

        pool_unit u_pool_unit (
            .i_op     (op),
            .i_win00  (win00),
            .i_win01  (win01),
            .i_win10  (win10),
            .i_win11  (win11),
            .o_result (pool_res[c*PIX_BW +: PIX_BW])
        );
    end

    // Counters, handshakes and output register
    pool_ctrl u_pool_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_valid   (i_valid),
        .o_ready   (o_ready),
        .i_pool_op (i_pool_op),
        .o_op      (op),
        .o_shift   (shift),
        .o_col     (col),
        .i_result  (pool_res),
        .o_valid   (o_valid),
        .o_pool    (o_pool),
        .o_last    (o_last),
        .i_ready   (i_ready)
    );

endmodule

// File: pool_ctrl.sv
module pool_ctrl
    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Pixel input handshake
    input  logic                 i_valid,
    output logic                 o_ready,
    input  pool_op_e             i_pool_op,

    // To line buffers and pool units
    output pool_op_e             o_op,
    output logic                 o_shift,
    output logic [COL_BW-1:0]    o_col,
    input  logic [CI*PIX_BW-1:0] i_result,

    // Pooled output handshake
    output logic                 o_valid,
    output logic [CI*PIX_BW-1:0] o_pool,
    output logic                 o_last,
    input  logic                 i_ready
);

    pool_state_e       state;
    pool_state_e       state_next;
    pool_op_e          op_q;
    logic [COL_BW-1:0] col;
    logic [ROW_BW-1:0] row;
    logic              accept;
    logic              hold;
    logic              frame_start;
    logic              win_done;
    logic              last_win;
    logic              taken_last;

    //////////////////////////////
    // Handshake and strobes
    //////////////////////////////

    // Pending output that the sink is not taking
    assign hold    = o_valid & ~i_ready;
    assign o_ready = ~hold;
    assign accept  = i_valid & o_ready;
    assign o_shift = accept;
    assign o_col   = col;
    assign o_op    = op_q;

    assign frame_start = accept & (row == '0) & (col == '0);
    // Odd row and odd column close a 2x2 window
    assign win_done    = accept & row[0] & col[0];
    assign last_win    = win_done & (row == ROW_BW'(IMG_H - 1))
                       & (col[COL_BW-1:1] == (COL_BW-1)'(POOL_W - 1));
    assign taken_last  = o_valid & i_ready & o_last;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: if (accept) state_next = S_RUN;
            S_RUN: begin
                if (hold) begin
                    state_next = S_HOLD;
                end else if (taken_last && !accept) begin
                    state_next = S_IDLE;
                end
            end
            S_HOLD: begin
                // Back to idle only if no new frame has begun
                if (!hold) state_next = (taken_last && !accept) ? S_IDLE : S_RUN;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= S_IDLE;
            op_q    <= POOL_MAX;
            col     <= '0;
            row     <= '0;
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            state <= state_next;
            // Opcode is fixed for the frame
            if (frame_start) op_q <= i_pool_op;
            if (accept) begin
                if (col == COL_BW'(IMG_W - 1)) begin
                    col <= '0;
                    row <= (row == ROW_BW'(IMG_H - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            if (win_done) begin
                o_valid <= 1'b1;
                o_last  <= last_win;
            end else if (o_valid && i_ready) begin
                o_valid <= 1'b0;
                o_last  <= 1'b0;
            end
        end
    end

    // Pooled payload
    always_ff @(posedge clk) begin
        if (win_done) o_pool <= i_result;
    end

endmodule

// File: pool_unit.sv
module pool_unit
    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  pool_op_e          i_op,
    input  logic [PIX_BW-1:0] i_win00,
    input  logic [PIX_BW-1:0] i_win01,
    input  logic [PIX_BW-1:0] i_win10,
    input  logic [PIX_BW-1:0] i_win11,
    output logic [PIX_BW-1:0] o_result
);

    logic        [PIX_BW-1:0] max_top;
    logic        [PIX_BW-1:0] max_bot;
    logic        [PIX_BW-1:0] max_all;
    logic signed [PIX_BW+1:0] sum;
    logic signed [PIX_BW+1:0] avg;

    // Pairwise signed maxima, then the max of the pair
    assign max_top = ($signed(i_win00) > $signed(i_win01)) ? i_win00 : i_win01;
    assign max_bot = ($signed(i_win10) > $signed(i_win11)) ? i_win10 : i_win11;
    assign max_all = ($signed(max_top) > $signed(max_bot)) ? max_top : max_bot;

    // Two guard bits hold the sum of four words
    assign sum = $signed({{2{i_win00[PIX_BW-1]}}, i_win00})
               + $signed({{2{i_win01[PIX_BW-1]}}, i_win01})
               + $signed({{2{i_win10[PIX_BW-1]}}, i_win10})
               + $signed({{2{i_win11[PIX_BW-1]}}, i_win11});
    // Floor division by four
    assign avg = sum >>> 2;

    always_comb begin
        case (i_op)
            POOL_AVG: o_result = avg[PIX_BW-1:0];
            default:  o_result = max_all;
        endcase
    end

endmodule

// File: line_buffer.sv
module line_buffer
    import cnn_geom_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              i_shift,
    input  logic [PIX_BW-1:0] i_pixel,
    input  logic [COL_BW-1:0] i_col,

    output logic [PIX_BW-1:0] o_win00,
    output logic [PIX_BW-1:0] o_win01,
    output logic [PIX_BW-1:0] o_win10,
    output logic [PIX_BW-1:0] o_win11
);

    // Row above the current one, one entry per column
    logic [PIX_BW-1:0] row_mem [IMG_W];
    // Left neighbour in the current row
    logic [PIX_BW-1:0] prev_pix;
    logic [COL_BW-1:0] col_prev;

    // Wraps to the last column at column zero
    assign col_prev = i_col - 1'b1;

    //////////////////////////////
    // Storage update
    //////////////////////////////

    // The row entry at col_prev is refreshed one pixel late, with the
    // left neighbour, so both top entries of the window still hold the
    // previous row when the current pixel arrives
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < IMG_W; i++) begin
                row_mem[i] <= '0;
            end
            prev_pix <= '0;
        end else if (i_shift) begin
            row_mem[col_prev] <= prev_pix;
            prev_pix          <= i_pixel;
        end
    end

    //////////////////////////////
    // 2x2 window
    //////////////////////////////

    // Top row from memory, bottom row from the live stream
    assign o_win00 = row_mem[col_prev];
    assign o_win01 = row_mem[i_col];
    assign o_win10 = prev_pix;
    assign o_win11 = i_pixel;

endmodule

// File: relu_stage.sv
module relu_stage
    import cnn_geom_pkg::*;
(
    input  logic [CI*PIX_BW-1:0] i_pixel,
    output logic [CI*PIX_BW-1:0] o_pixel
);

    // One clamp per channel
    for (genvar c = 0; c < CI; c++) begin : g_ch
        logic [PIX_BW-1:0] ch_pix;
        logic              ch_neg;

        assign ch_pix = i_pixel[c*PIX_BW +: PIX_BW];
        // Sign bit of the channel word
        assign ch_neg = ch_pix[PIX_BW-1];

        assign o_pixel[c*PIX_BW +: PIX_BW] = ch_neg ? '0 : ch_pix;
    end

endmodule

// File: cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

    // Pooling function, selected once per frame
    typedef enum logic {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_op_e;

    // Pool controller FSM
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_RUN  = 2'd1,
        S_HOLD = 2'd2
    } pool_state_e;

endpackage

// File: cnn_geom_pkg.sv
package cnn_geom_pkg;

    //////////////////////////////
    // Channel and pixel format
    //////////////////////////////

    // Channels carried per pixel
    localparam int CI     = 3;
    // Signed pixel word
    localparam int PIX_BW = 16;

    //////////////////////////////
    // Frame geometry
    //////////////////////////////

    localparam int IMG_W  = 8;
    localparam int IMG_H  = 8;
    // Pooled row length for 2x2, stride 2
    localparam int POOL_W = IMG_W / 2;

    // Counter widths sized for IMG_W and IMG_H
    localparam int COL_BW = 3;
    localparam int ROW_BW = 3;

endpackage
